// File: hw/rgs_pkg.sv
/*
 * Shared definitions for the buffered read regroup scheduler
 * beat descriptor, scheduler states and sizing constants
 */

`default_nettype none

package rgs_pkg;

	////////////////////
	// sizing
	////////////////////

	// width of a word count and of an end-of-packet position
	localparam int VALID_WIDTH = 4;

	// largest count per input beat and per regrouped output group
	localparam int MAX_WORDS = 4;

	// FIFO address bits, giving 16 entries per crossing FIFO
	localparam int FIFO_ADDR_W = 4;

	////////////////////
	// beat descriptor
	////////////////////

	// one write-side beat, described only by counts
	// eop_position of 0 means the packet continues past this beat
	// a value k from 1 to num_valid marks the k-th word as the last of the packet
	typedef struct packed {
		logic [VALID_WIDTH-1:0] num_valid;
		logic [VALID_WIDTH-1:0] eop_position;
	} beat_t;

	////////////////////
	// scheduler FSM
	////////////////////

	// ACCUM collects words of the open packet and emits full groups
	// FLUSH_CARRY emits the leftover head words of a packet that ended
	// with more than one group's worth pending
	typedef enum logic [1:0] {
		ACCUM,
		FLUSH_CARRY
	} sched_state_t;

endpackage

`default_nettype wire

// File: hw/rgs_async_fifo.sv
/*
 * Dual-clock FIFO with gray-coded pointers and two-flop synchronizers
 * full and empty are registered, output data is registered on a read
 */

`timescale 1ns/1ps
`default_nettype none

module rgs_async_fifo #(
	parameter int WIDTH = 8,
	parameter int ADDR_W = rgs_pkg::FIFO_ADDR_W
) (
	input wire logic wr_clk,
	input wire logic wr_aclr,
	input wire logic wr_en,
	input wire logic [WIDTH-1:0] wr_data,
	output logic full,

	input wire logic rd_clk,
	input wire logic rd_aclr,
	input wire logic rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic empty
);

	// pointers carry one extra bit to tell a full ring from an empty one
	localparam int PTR_W = ADDR_W + 1;
	localparam int DEPTH = 1 << ADDR_W;

	logic [WIDTH-1:0] mem [DEPTH];

	// write side pointers and the read pointer as seen from the write clock
	logic [PTR_W-1:0] wr_bin, wr_bin_next;
	logic [PTR_W-1:0] wr_gray, wr_gray_next;
	logic [PTR_W-1:0] rd_gray_s1, rd_gray_s2;
	logic wr_push;
	logic full_next;

	// read side pointers and the write pointer as seen from the read clock
	logic [PTR_W-1:0] rd_bin, rd_bin_next;
	logic [PTR_W-1:0] rd_gray, rd_gray_next;
	logic [PTR_W-1:0] wr_gray_s1, wr_gray_s2;
	logic rd_pop;
	logic empty_next;

	////////////////////
	// write side
	////////////////////

	// a write while full is dropped and leaves the pointers alone
	assign wr_push = wr_en & ~full;
	assign wr_bin_next = wr_bin + PTR_W'(wr_push);
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

	// full when the next write pointer has lapped the read pointer once,
	// which in gray code shows as the top two bits inverted
	assign full_next = (wr_gray_next ==
		{~rd_gray_s2[PTR_W-1:PTR_W-2], rd_gray_s2[PTR_W-3:0]});

	always_ff @(posedge wr_clk or posedge wr_aclr) begin
		if (wr_aclr) begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
			full <= 1'b0;
		end else begin
			wr_bin <= wr_bin_next;
			wr_gray <= wr_gray_next;
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
			full <= full_next;
		end
	end

	// storage has no reset, only slots behind the write pointer are read
	always_ff @(posedge wr_clk) begin
		if (wr_push) begin
			mem[wr_bin[ADDR_W-1:0]] <= wr_data;
		end
	end

	////////////////////
	// read side
	////////////////////

	assign rd_pop = rd_en & ~empty;
	assign rd_bin_next = rd_bin + PTR_W'(rd_pop);
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	// empty when the next read pointer catches the synchronized write pointer
	assign empty_next = (rd_gray_next == wr_gray_s2);

	always_ff @(posedge rd_clk or posedge rd_aclr) begin
		if (rd_aclr) begin
			rd_bin <= '0;
			rd_gray <= '0;
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
			empty <= 1'b1;
		end else begin
			rd_bin <= rd_bin_next;
			rd_gray <= rd_gray_next;
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
			empty <= empty_next;
		end
	end

	// no show-ahead, data shows up one read clock after the pop
	always_ff @(posedge rd_clk) begin
		if (rd_pop) begin
			rd_data <= mem[rd_bin[ADDR_W-1:0]];
		end
	end

endmodule

`default_nettype wire

// File: hw/rgs_read_scheduler.sv
/*
 * Mid-domain read regrouper
 * packs incoming word counts into groups of 4 and never lets a group
 * cross a packet end, words after an end are carried to the next group
 */

`timescale 1ns/1ps
`default_nettype none

module rgs_read_scheduler (
	input wire logic clk_mid,
	input wire logic aclr_mid,
	input wire rgs_pkg::beat_t beat,
	output logic sched_wait,
	output logic [rgs_pkg::VALID_WIDTH-1:0] group_count
);

	import rgs_pkg::*;

	localparam logic [VALID_WIDTH-1:0] GROUP_WORDS = VALID_WIDTH'(MAX_WORDS);

	sched_state_t state, state_next;

	// words of the open packet not yet emitted, always 0 to 3
	logic [VALID_WIDTH-1:0] acc, acc_next;

	// head words left over when a packet ends with more than one group pending
	logic [VALID_WIDTH-1:0] carry, carry_next;

	logic [VALID_WIDTH-1:0] group_next;

	// sum is the open packet when this beat has no end, at most 3 + 4
	logic [VALID_WIDTH-1:0] sum;

	// head is the closing packet up to the end position, tail is the next packet
	logic [VALID_WIDTH-1:0] head;
	logic [VALID_WIDTH-1:0] tail;
	logic has_eop;

	assign has_eop = |beat.eop_position;
	assign sum = acc + beat.num_valid;
	assign head = acc + beat.eop_position;
	assign tail = beat.num_valid - beat.eop_position;

	// the beat is held at the FIFO side while the carry is flushed
	assign sched_wait = (state == FLUSH_CARRY);

	////////////////////
	// next state
	////////////////////

	always_comb begin
		state_next = state;
		acc_next = acc;
		carry_next = carry;
		group_next = '0;

		case (state)
			ACCUM: begin
				if (!has_eop) begin
					// mid packet, emit a full group as soon as one is ready
					if (sum >= GROUP_WORDS) begin
						group_next = GROUP_WORDS;
						acc_next = sum - GROUP_WORDS;
					end else begin
						acc_next = sum;
					end
				end else begin
					// packet ends here, close it out even if the group is short
					if (head > GROUP_WORDS) begin
						group_next = GROUP_WORDS;
						carry_next = head - GROUP_WORDS;
						state_next = FLUSH_CARRY;
					end else begin
						group_next = head;
					end
					// words after the end open the next packet
					acc_next = tail;
				end
			end

			FLUSH_CARRY: begin
				// the incoming beat is not taken in this cycle
				group_next = carry;
				carry_next = '0;
				state_next = ACCUM;
			end

			default: begin
				state_next = ACCUM;
			end
		endcase
	end

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge clk_mid or posedge aclr_mid) begin
		if (aclr_mid) begin
			state <= ACCUM;
			acc <= '0;
			carry <= '0;
			group_count <= '0;
		end else begin
			state <= state_next;
			acc <= acc_next;
			carry <= carry_next;
			// a group shows up on the edge after its beat was accepted
			group_count <= group_next;
		end
	end

endmodule

`default_nettype wire

// File: hw/rgs_buffered_read_scheduler.sv
/*
 * Buffered read regroup scheduler
 * write FIFO into the mid-domain regrouper, read FIFO out to the read
 * clock, only word counts and end positions travel
 */

`timescale 1ns/1ps
`default_nettype none

module rgs_buffered_read_scheduler (
	input wire logic clk_wr,
	input wire logic aclr_wr,
	input wire logic [rgs_pkg::VALID_WIDTH-1:0] wr_num_valid,
	input wire logic [rgs_pkg::VALID_WIDTH-1:0] wr_eop_position,
	output logic wr_overflow,

	input wire logic clk_mid,
	input wire logic aclr_mid,
	output logic rd_overflow,

	input wire logic clk_rd,
	input wire logic aclr_rd,
	output logic [rgs_pkg::VALID_WIDTH-1:0] rd_num_valid
);

	import rgs_pkg::*;

	localparam int BEAT_W = $bits(beat_t);

	////////////////////
	// write side
	////////////////////

	beat_t wr_beat_r;

	// input register, a zero count after reset keeps the FIFO idle
	always_ff @(posedge clk_wr or posedge aclr_wr) begin
		if (aclr_wr) begin
			wr_beat_r <= '0;
		end else begin
			wr_beat_r.num_valid <= wr_num_valid;
			wr_beat_r.eop_position <= wr_eop_position;
		end
	end

	logic wrfifo_empty;
	logic wrfifo_rdreq;
	logic wrfifo_q_valid;
	logic [BEAT_W-1:0] wrfifo_q;
	logic sched_wait;
	beat_t sched_beat;

	// only beats that carry words are written
	rgs_async_fifo #(
		.WIDTH(BEAT_W),
		.ADDR_W(FIFO_ADDR_W)
	) wr_fifo (
		.wr_clk(clk_wr),
		.wr_aclr(aclr_wr),
		.wr_en(|wr_beat_r.num_valid),
		.wr_data(wr_beat_r),
		.full(wr_overflow),
		.rd_clk(clk_mid),
		.rd_aclr(aclr_mid),
		.rd_en(wrfifo_rdreq),
		.rd_data(wrfifo_q),
		.empty(wrfifo_empty)
	);

	// refill the output slot when it is free or being consumed this cycle
	assign wrfifo_rdreq = ~wrfifo_empty & (~wrfifo_q_valid | ~sched_wait);

	always_ff @(posedge clk_mid or posedge aclr_mid) begin
		if (aclr_mid) begin
			wrfifo_q_valid <= 1'b0;
		end else if (wrfifo_rdreq) begin
			wrfifo_q_valid <= 1'b1;
		end else if (!sched_wait) begin
			wrfifo_q_valid <= 1'b0;
		end
	end

	// a stale FIFO word looks like an idle beat to the scheduler
	assign sched_beat = wrfifo_q_valid ? beat_t'(wrfifo_q) : '0;

	////////////////////
	// regrouper
	////////////////////

	logic [VALID_WIDTH-1:0] sched_count;

	rgs_read_scheduler sched (
		.clk_mid(clk_mid),
		.aclr_mid(aclr_mid),
		.beat(sched_beat),
		.sched_wait(sched_wait),
		.group_count(sched_count)
	);

	////////////////////
	// read side
	////////////////////

	logic rdfifo_empty;
	logic rdfifo_q_valid;
	logic [VALID_WIDTH-1:0] rdfifo_q;

	rgs_async_fifo #(
		.WIDTH(VALID_WIDTH),
		.ADDR_W(FIFO_ADDR_W)
	) rd_fifo (
		.wr_clk(clk_mid),
		.wr_aclr(aclr_mid),
		.wr_en(|sched_count),
		.wr_data(sched_count),
		.full(rd_overflow),
		.rd_clk(clk_rd),
		.rd_aclr(aclr_rd),
		.rd_en(~rdfifo_empty),
		.rd_data(rdfifo_q),
		.empty(rdfifo_empty)
	);

	// the read side always drains, so every non-empty cycle pops one group
	always_ff @(posedge clk_rd or posedge aclr_rd) begin
		if (aclr_rd) begin
			rdfifo_q_valid <= 1'b0;
			rd_num_valid <= '0;
		end else begin
			rdfifo_q_valid <= ~rdfifo_empty;
			rd_num_valid <= rdfifo_q_valid ? rdfifo_q : '0;
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_rgs_buffered_read_scheduler.sv
/*
 * Testbench for the buffered read regroup scheduler
 * three clocks, xorshift packet traffic, a group-level packet model and
 * immediate assertions on the regrouped read-side counts
 */

`timescale 1ns/1ps
`default_nettype none

module tb_rgs_buffered_read_scheduler;

	import rgs_pkg::*;

	logic clk_wr;
	logic clk_mid;
	logic clk_rd;
	logic aclr_wr;
	logic aclr_mid;
	logic aclr_rd;
	logic [VALID_WIDTH-1:0] wr_num_valid;
	logic [VALID_WIDTH-1:0] wr_eop_position;
	logic [VALID_WIDTH-1:0] rd_num_valid;
	logic wr_overflow;
	logic rd_overflow;

	// the overflow burst shortens this half period of the write clock
	int wr_half = 7;

	// the checker walks the expected groups by index in packet order
	int exp_groups[$];
	int seen_groups = 0;
	int stim_cycles = 0;
	int rd_cycles = 0;
	logic check_en = 1'b0;
	logic saw_wr_overflow = 1'b0;
	logic [31:0] rng_state = 32'ha3141539;

	rgs_buffered_read_scheduler uut (
		.clk_wr(clk_wr),
		.aclr_wr(aclr_wr),
		.wr_num_valid(wr_num_valid),
		.wr_eop_position(wr_eop_position),
		.wr_overflow(wr_overflow),
		.clk_mid(clk_mid),
		.aclr_mid(aclr_mid),
		.rd_overflow(rd_overflow),
		.clk_rd(clk_rd),
		.aclr_rd(aclr_rd),
		.rd_num_valid(rd_num_valid)
	);

	////////////////////
	// clocks and resets
	////////////////////

	initial begin
		clk_rd = 1'b0;
		forever #5 clk_rd = ~clk_rd;
	end

	initial begin
		clk_mid = 1'b0;
		forever #4 clk_mid = ~clk_mid;
	end

	initial begin
		clk_wr = 1'b0;
		forever #(wr_half) clk_wr = ~clk_wr;
	end

	// each reset is held for two cycles of its own clock
	initial begin
		aclr_rd = 1'b1;
		repeat (2) @(posedge clk_rd);
		@(negedge clk_rd);
		aclr_rd = 1'b0;
	end

	initial begin
		aclr_mid = 1'b1;
		repeat (2) @(posedge clk_mid);
		@(negedge clk_mid);
		aclr_mid = 1'b0;
	end

	initial begin
		aclr_wr = 1'b1;
		repeat (2) @(posedge clk_wr);
		@(negedge clk_wr);
		aclr_wr = 1'b0;
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		rng_state = xorshift(rng_state);
		return rng_state % n;
	endfunction

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic raise_error(input string msg);
		fail_run($sformatf("error at time %0t: %s", $time, msg));
	endtask

	// a packet of len words leaves as full groups followed by the short remainder
	task automatic queue_packet(input int len);
		repeat (len / MAX_WORDS) exp_groups.push_back(MAX_WORDS);
		if (len % MAX_WORDS != 0) begin
			exp_groups.push_back(len % MAX_WORDS);
		end
	endtask

	task automatic drive_beat(input int nv, input int eop);
		@(negedge clk_wr);
		wr_num_valid = VALID_WIDTH'(nv);
		wr_eop_position = VALID_WIDTH'(eop);
		stim_cycles++;
	endtask

	task automatic wait_drain();
		while (seen_groups != exp_groups.size()) @(negedge clk_wr);
	endtask

	// random packets are cut into beats of 1 to 4 words with at most one end per beat
	// words after an end open the next packet and zero_pct mixes in empty beats
	task automatic send_random_packets(input int n_pkts, input int zero_pct);
		int lens[$];
		int idx;
		int rem;
		int nv;
		int tail;
		for (int i = 0; i < n_pkts; i++) begin
			lens.push_back(1 + int'(rand_below(23)));
			queue_packet(lens[i]);
		end
		idx = 0;
		rem = lens[0];
		while (idx < n_pkts) begin
			if (zero_pct > 0 && int'(rand_below(100)) < zero_pct) begin
				drive_beat(0, 0);
			end else begin
				nv = 1 + int'(rand_below(4));
				if (nv < rem) begin
					drive_beat(nv, 0);
					rem -= nv;
				end else begin
					// the tail must leave the next packet open so the beat has one end
					tail = nv - rem;
					if (idx + 1 < n_pkts) begin
						if (tail > lens[idx + 1] - 1) tail = lens[idx + 1] - 1;
					end else begin
						tail = 0;
					end
					drive_beat(rem + tail, rem);
					idx++;
					if (idx < n_pkts) rem = lens[idx] - tail;
				end
			end
		end
		drive_beat(0, 0);
	endtask

	// final beats whose head passes 4 words send the scheduler
	// through FLUSH_CARRY with wait high for one cycle
	task automatic send_long_heads();
		queue_packet(5);
		queue_packet(7);
		queue_packet(8);
		queue_packet(5);
		queue_packet(6);
		queue_packet(7);
		queue_packet(5);
		drive_beat(1, 0);
		drive_beat(4, 4);
		drive_beat(3, 0);
		drive_beat(4, 4);
		// length 8 always closes with a head of exactly 4
		drive_beat(3, 0);
		drive_beat(1, 0);
		drive_beat(4, 4);
		// head of 5 plus one word of the following packet of 6
		drive_beat(2, 0);
		drive_beat(4, 3);
		drive_beat(4, 0);
		drive_beat(1, 1);
		// two long heads close together so the beat between them can meet the carry flush
		drive_beat(3, 0);
		drive_beat(4, 4);
		drive_beat(1, 0);
		drive_beat(4, 4);
		drive_beat(0, 0);
	endtask

	////////////////////
	// checkers
	////////////////////

	// every nonzero read count must be the next expected group
	always @(negedge clk_rd) begin : check_groups
		if (check_en && rd_num_valid != '0) begin
			assert (seen_groups < exp_groups.size())
				else raise_error($sformatf("group of %0d with no packet pending", rd_num_valid));
			assert (int'(rd_num_valid) == exp_groups[seen_groups])
				else raise_error($sformatf("group %0d is %0d, expected %0d", seen_groups,
					rd_num_valid, exp_groups[seen_groups]));
			seen_groups++;
		end
	end

	always @(negedge clk_mid) begin
		if (check_en) begin
			assert (!rd_overflow) else raise_error("rd_overflow set in normal traffic");
		end
	end

	always @(negedge clk_wr) begin
		if (check_en) begin
			assert (!wr_overflow) else raise_error("wr_overflow set in normal traffic");
		end
	end

	// the limit grows with the stimulus, so only a stuck run reaches it
	always @(posedge clk_rd) begin
		rd_cycles++;
		if (rd_cycles > 4 * stim_cycles + 200) begin
			fail_run($sformatf("timeout: run still going after %0d read clock cycles",
				rd_cycles));
		end
	end

	////////////////////
	// test sequence
	////////////////////

	initial begin
		wr_num_valid = '0;
		wr_eop_position = '0;
		while (aclr_wr || aclr_mid || aclr_rd) @(negedge clk_wr);
		check_en = 1'b1;

		// idle outputs after reset and before the first write
		repeat (10) begin
			drive_beat(0, 0);
			assert (rd_num_valid == '0 && !wr_overflow)
				else raise_error("outputs not idle after reset");
		end

		send_random_packets(40, 0);
		wait_drain();
		send_long_heads();
		wait_drain();
		send_random_packets(30, 25);
		wait_drain();

		// nothing more comes out once traffic stops
		repeat (30) begin
			drive_beat(0, 0);
			assert (rd_num_valid == '0) else raise_error("output not idle after traffic");
		end

		// fast write burst that the mid side cannot keep up with
		check_en = 1'b0;
		wr_half = 1;
		repeat (40) begin
			drive_beat(4, 4);
			if (wr_overflow) saw_wr_overflow = 1'b1;
		end
		drive_beat(0, 0);
		assert (saw_wr_overflow) begin
			$display("Simulation passed");
			$finish;
		end else begin
			raise_error("wr_overflow never rose in the write burst");
		end
	end

endmodule

`default_nettype wire

// File: ilkn_read_regroup.f
hw/rgs_pkg.sv
hw/rgs_async_fifo.sv
hw/rgs_read_scheduler.sv
hw/rgs_buffered_read_scheduler.sv
sim/tb_rgs_buffered_read_scheduler.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the regroup scheduler testbench with Verilator.
# Exits nonzero when the build or the run fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
	-f ilkn_read_regroup.f \
	--top-module tb_rgs_buffered_read_scheduler \
	-Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
